// ==== hw/hazardPkg.sv ====
package hazardPkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////
    typedef logic [31:0] instrWord;
    typedef logic [4:0]  regAddr;
    typedef logic [1:0]  tuseVal;
    typedef logic [1:0]  tnewVal;
    typedef logic [1:0]  fwdSrc;

    // Hazard info carried down the pipe, all zero is a bubble
    typedef struct packed {
        tuseVal tuseRs;
        regAddr readRs;
        tuseVal tuseRt;
        regAddr readRt;
        tnewVal tnew;
        regAddr writeA;
    } atInfo;

    typedef struct packed {
        fwdSrc rs;
        fwdSrc rt;
    } fwdSel;

    // Bypass sources
    localparam fwdSrc fwdNone  = 2'd0;
    localparam fwdSrc fwdFromE = 2'd1;
    localparam fwdSrc fwdFromM = 2'd2;
    localparam fwdSrc fwdFromW = 2'd3;

    localparam regAddr regZero = 5'd0;
    localparam regAddr regRa   = 5'd31;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////
    localparam logic [5:0] opR        = 6'h00;
    localparam logic [5:0] opRegimm   = 6'h01;
    localparam logic [5:0] opJ        = 6'h02;
    localparam logic [5:0] opJal      = 6'h03;
    localparam logic [5:0] opBeq      = 6'h04;
    localparam logic [5:0] opBne      = 6'h05;
    localparam logic [5:0] opBlez     = 6'h06;
    localparam logic [5:0] opBgtz     = 6'h07;
    localparam logic [5:0] opAddi     = 6'h08;
    localparam logic [5:0] opAddiu    = 6'h09;
    localparam logic [5:0] opSlti     = 6'h0a;
    localparam logic [5:0] opSltiu    = 6'h0b;
    localparam logic [5:0] opAndi     = 6'h0c;
    localparam logic [5:0] opOri      = 6'h0d;
    localparam logic [5:0] opXori     = 6'h0e;
    localparam logic [5:0] opLui      = 6'h0f;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opLb       = 6'h20;
    localparam logic [5:0] opLh       = 6'h21;
    localparam logic [5:0] opLw       = 6'h23;
    localparam logic [5:0] opLbu      = 6'h24;
    localparam logic [5:0] opLhu      = 6'h25;
    localparam logic [5:0] opSb       = 6'h28;
    localparam logic [5:0] opSh       = 6'h29;
    localparam logic [5:0] opSw       = 6'h2b;

    ////////////////////////////////////////
    // Funct codes, SPECIAL and SPECIAL2
    ////////////////////////////////////////
    localparam logic [5:0] functSll   = 6'h00;
    localparam logic [5:0] functSrl   = 6'h02;
    localparam logic [5:0] functSra   = 6'h03;
    localparam logic [5:0] functSllv  = 6'h04;
    localparam logic [5:0] functSrlv  = 6'h06;
    localparam logic [5:0] functSrav  = 6'h07;
    localparam logic [5:0] functJr    = 6'h08;
    localparam logic [5:0] functJalr  = 6'h09;
    localparam logic [5:0] functMovz  = 6'h0a;
    localparam logic [5:0] functMfhi  = 6'h10;
    localparam logic [5:0] functMthi  = 6'h11;
    localparam logic [5:0] functMflo  = 6'h12;
    localparam logic [5:0] functMtlo  = 6'h13;
    localparam logic [5:0] functMult  = 6'h18;
    localparam logic [5:0] functMultu = 6'h19;
    localparam logic [5:0] functDiv   = 6'h1a;
    localparam logic [5:0] functDivu  = 6'h1b;
    localparam logic [5:0] functAdd   = 6'h20;
    localparam logic [5:0] functAddu  = 6'h21;
    localparam logic [5:0] functSub   = 6'h22;
    localparam logic [5:0] functSubu  = 6'h23;
    localparam logic [5:0] functAnd   = 6'h24;
    localparam logic [5:0] functOr    = 6'h25;
    localparam logic [5:0] functXor   = 6'h26;
    localparam logic [5:0] functNor   = 6'h27;
    localparam logic [5:0] functSlt   = 6'h2a;
    localparam logic [5:0] functSltu  = 6'h2b;
    localparam logic [5:0] functMsub  = 6'h04;

    // REGIMM branches, selected by the rt field
    localparam regAddr rtBltz   = 5'h00;
    localparam regAddr rtBgez   = 5'h01;
    localparam regAddr rtBgezal = 5'h11;

endpackage

// ==== hw/atDecoder.sv ====
`timescale 1ns/1ps

module atDecoder (
    input  hazardPkg::instrWord instr,
    output hazardPkg::atInfo    info
);
    import hazardPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr     rs;
    regAddr     rt;
    regAddr     rd;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    function automatic atInfo mkInfo(
        input tuseVal tuseRs,
        input regAddr readRs,
        input tuseVal tuseRt,
        input regAddr readRt,
        input tnewVal tnew,
        input regAddr writeA
    );
        atInfo r;
        r.tuseRs = tuseRs;
        r.readRs = readRs;
        r.tuseRt = tuseRt;
        r.readRt = readRt;
        r.tnew   = tnew;
        r.writeA = writeA;
        return r;
    endfunction

    always_comb begin
        info = '0;
        case (opcode)
            ////////////////////////////////////////
            // SPECIAL group
            ////////////////////////////////////////
            opR: begin
                case (funct)
                    functAdd, functAddu, functSub, functSubu,
                    functAnd, functOr, functXor, functNor,
                    functSllv, functSrlv, functSrav,
                    functSlt, functSltu:
                        info = mkInfo(2'd1, rs, 2'd1, rt, 2'd2, rd);

                    // Shift amount is immediate, rs unused
                    functSll, functSrl, functSra:
                        info = mkInfo(2'd0, regZero, 2'd1, rt, 2'd2, rd);

                    // HI/LO only, no GPR result
                    functMult, functMultu, functDiv, functDivu:
                        info = mkInfo(2'd1, rs, 2'd1, rt, 2'd0, regZero);

                    functMfhi, functMflo:
                        info = mkInfo(2'd0, regZero, 2'd0, regZero, 2'd2, rd);

                    functMthi, functMtlo:
                        info = mkInfo(2'd1, rs, 2'd0, regZero, 2'd0, regZero);

                    // Jump target needed in Decode
                    functJr:
                        info = mkInfo(2'd0, rs, 2'd0, regZero, 2'd0, regZero);

                    functJalr:
                        info = mkInfo(2'd0, rs, 2'd0, regZero, 2'd1, rd);

                    // Condition on rt resolved early
                    functMovz:
                        info = mkInfo(2'd1, rs, 2'd0, rt, 2'd2, rd);

                    default:
                        info = '0;
                endcase
            end

            opSpecial2: begin
                if (funct == functMsub) begin
                    info = mkInfo(2'd1, rs, 2'd1, rt, 2'd0, regZero);
                end
            end

            // Immediate ALU
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori:
                info = mkInfo(2'd1, rs, 2'd0, regZero, 2'd2, rt);

            opLui:
                info = mkInfo(2'd0, regZero, 2'd0, regZero, 2'd1, rt);

            ////////////////////////////////////////
            // Memory access
            ////////////////////////////////////////
            opLw, opLb, opLbu, opLh, opLhu:
                info = mkInfo(2'd1, rs, 2'd0, regZero, 2'd3, rt);

            // Store data is not needed until Memory
            opSw, opSb, opSh:
                info = mkInfo(2'd1, rs, 2'd2, rt, 2'd0, regZero);

            // Branches compare in Decode
            opBeq, opBne:
                info = mkInfo(2'd0, rs, 2'd0, rt, 2'd0, regZero);

            opBlez, opBgtz:
                info = mkInfo(2'd0, rs, 2'd0, regZero, 2'd0, regZero);

            opRegimm: begin
                case (rt)
                    rtBltz, rtBgez:
                        info = mkInfo(2'd0, rs, 2'd0, regZero, 2'd0, regZero);
                    rtBgezal:
                        info = mkInfo(2'd0, rs, 2'd0, regZero, 2'd1, regRa);
                    default:
                        info = '0;
                endcase
            end

            // j touches no register and stays a bubble
            opJ:
                info = '0;

            opJal:
                info = mkInfo(2'd0, regZero, 2'd0, regZero, 2'd1, regRa);

            default:
                info = '0;
        endcase
    end

endmodule

// ==== hw/atPipeline.sv ====
`timescale 1ns/1ps

module atPipeline (
    input  logic             clk,
    input  logic             rst,
    input  hazardPkg::atInfo decInfo,
    input  logic             stall,
    output hazardPkg::atInfo eInfo,
    output hazardPkg::atInfo mInfo,
    output hazardPkg::atInfo wInfo
);
    import hazardPkg::*;

    atInfo eNext;
    atInfo mNext;
    atInfo wNext;

    // One stage older, Tnew counts down and stops at 0
    function automatic atInfo ageInfo(input atInfo cur);
        atInfo r;
        r = cur;
        if (cur.tnew != 2'd0) begin
            r.tnew = cur.tnew - 2'd1;
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Next-state values
    ////////////////////////////////////////

    // Decode held on stall, Execute takes a bubble
    always_comb begin
        if (stall) begin
            eNext = '0;
        end else begin
            eNext = ageInfo(decInfo);
        end
    end

    // Older stages always advance
    assign mNext = ageInfo(eInfo);
    assign wNext = ageInfo(mInfo);

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            eInfo <= '0;
            mInfo <= '0;
            wInfo <= '0;
        end else begin
            eInfo <= eNext;
            mInfo <= mNext;
            wInfo <= wNext;
        end
    end

endmodule

// ==== hw/stallDetector.sv ====
`timescale 1ns/1ps

module stallDetector (
    input  hazardPkg::atInfo decInfo,
    input  hazardPkg::atInfo eInfo,
    input  hazardPkg::atInfo mInfo,
    output logic             stall
);
    import hazardPkg::*;

    logic rsHitE;
    logic rsHitM;
    logic rtHitE;
    logic rtHitM;

    // Operand needed before the producer can deliver it
    function automatic logic mustWait(
        input regAddr readA,
        input tuseVal tuse,
        input atInfo  prod
    );
        logic match;
        match = (readA != regZero) && (readA == prod.writeA);
        return match && (tuse < prod.tnew);
    endfunction

    assign rsHitE = mustWait(decInfo.readRs, decInfo.tuseRs, eInfo);
    assign rsHitM = mustWait(decInfo.readRs, decInfo.tuseRs, mInfo);
    assign rtHitE = mustWait(decInfo.readRt, decInfo.tuseRt, eInfo);
    assign rtHitM = mustWait(decInfo.readRt, decInfo.tuseRt, mInfo);

    // Writeback is left out, its Tnew is always 0
    assign stall = rsHitE | rsHitM | rtHitE | rtHitM;

endmodule

// ==== hw/forwardSelect.sv ====
`timescale 1ns/1ps

module forwardSelect (
    input  hazardPkg::atInfo decInfo,
    input  hazardPkg::atInfo eInfo,
    input  hazardPkg::atInfo mInfo,
    input  hazardPkg::atInfo wInfo,
    output hazardPkg::fwdSel fwdD,
    output hazardPkg::fwdSel fwdE
);
    import hazardPkg::*;

    // Nearest stage writing readA wins
    // Source only given when that result already exists
    function automatic fwdSrc pickSrc(
        input regAddr readA,
        input atInfo  eStg,
        input atInfo  mStg,
        input atInfo  wStg
    );
        fwdSrc src;
        src = fwdNone;
        if (readA == regZero) begin
            src = fwdNone;
        end else if (readA == eStg.writeA) begin
            src = (eStg.tnew == 2'd0) ? fwdFromE : fwdNone;
        end else if (readA == mStg.writeA) begin
            src = (mStg.tnew == 2'd0) ? fwdFromM : fwdNone;
        end else if (readA == wStg.writeA) begin
            src = (wStg.tnew == 2'd0) ? fwdFromW : fwdNone;
        end
        return src;
    endfunction

    ////////////////////////////////////////
    // Decode operands
    ////////////////////////////////////////
    assign fwdD.rs = pickSrc(decInfo.readRs, eInfo, mInfo, wInfo);
    assign fwdD.rt = pickSrc(decInfo.readRt, eInfo, mInfo, wInfo);

    ////////////////////////////////////////
    // Execute operands
    ////////////////////////////////////////

    // A bubble in the Execute slot never matches a nonzero read
    assign fwdE.rs = pickSrc(eInfo.readRs, '0, mInfo, wInfo);
    assign fwdE.rt = pickSrc(eInfo.readRt, '0, mInfo, wInfo);

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  logic                clk,
    input  logic                rst,
    input  hazardPkg::instrWord instr,
    output logic                stall,
    output hazardPkg::fwdSel    fwdD,
    output hazardPkg::fwdSel    fwdE
);
    import hazardPkg::*;

    atInfo decInfo;
    atInfo eInfo;
    atInfo mInfo;
    atInfo wInfo;

    atDecoder decoder_i (
        .instr (instr),
        .info  (decInfo)
    );

    // Stage copies for Execute, Memory, Writeback
    atPipeline pipe_i (
        .clk     (clk),
        .rst     (rst),
        .decInfo (decInfo),
        .stall   (stall),
        .eInfo   (eInfo),
        .mInfo   (mInfo),
        .wInfo   (wInfo)
    );

    stallDetector stall_i (
        .decInfo (decInfo),
        .eInfo   (eInfo),
        .mInfo   (mInfo),
        .stall   (stall)
    );

    forwardSelect fwd_i (
        .decInfo (decInfo),
        .eInfo   (eInfo),
        .mInfo   (mInfo),
        .wInfo   (wInfo),
        .fwdD    (fwdD),
        .fwdE    (fwdE)
    );

endmodule

// ==== tests/hazardUnitTb.sv ====
`timescale 1ns/1ps

module hazardUnitTb;
    import hazardPkg::*;

    localparam fwdSel noFwd = '0;

    logic     clk = 1'b0;
    logic     rst;
    instrWord instr;
    logic     stall;
    fwdSel    fwdD;
    fwdSel    fwdE;

    int          errors = 0;
    int          checks = 0;
    int unsigned seedDummy;

    // Stimulus and expected values, one entry per cycle
    string    rowName[$];
    instrWord rowInstr[$];
    logic     rowStall[$];
    fwdSel    rowFwdD[$];
    fwdSel    rowFwdE[$];

    hazardUnit dut_i (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .stall (stall),
        .fwdD  (fwdD),
        .fwdE  (fwdE)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Instruction assembly
    ////////////////////////////////////////
    function automatic instrWord rType(input regAddr rs, input regAddr rt, input regAddr rd,
                                       input logic [5:0] funct);
        return {opR, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic instrWord iType(input logic [5:0] op, input regAddr rs, input regAddr rt,
                                       input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instrWord jType(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    // add into r0 from r16..r23, which nothing in the tests writes
    function automatic instrWord fillerInstr();
        regAddr a;
        regAddr b;
        a = regAddr'(16 + $urandom % 8);
        b = regAddr'(16 + $urandom % 8);
        return rType(a, b, regZero, functAdd);
    endfunction

    function automatic fwdSel fwdPair(input fwdSrc rs, input fwdSrc rt);
        fwdSel s;
        s.rs = rs;
        s.rt = rt;
        return s;
    endfunction

    task automatic addRow(input string name, input instrWord word, input logic expStall,
                          input fwdSel expD, input fwdSel expE);
        rowName.push_back(name);
        rowInstr.push_back(word);
        rowStall.push_back(expStall);
        rowFwdD.push_back(expD);
        rowFwdE.push_back(expE);
    endtask

    ////////////////////////////////////////
    // Table
    ////////////////////////////////////////
    task automatic buildTable();
        instrWord lwR8;
        instrWord addUse;
        instrWord beqR8;
        instrWord addR9;
        instrWord beqR9;
        instrWord addR10;
        instrWord addR11;
        instrWord jrR31;
        instrWord swR8;
        instrWord addUse9;
        lwR8    = iType(opLw, 5'd29, 5'd8, 16'd4);
        addUse  = rType(5'd11, 5'd8, 5'd10, functAdd);
        beqR8   = iType(opBeq, 5'd8, regZero, 16'd3);
        addR9   = rType(5'd12, 5'd13, 5'd9, functAdd);
        beqR9   = iType(opBeq, 5'd9, 5'd14, 16'd2);
        addR10  = rType(5'd12, 5'd13, 5'd10, functAdd);
        addR11  = rType(5'd10, 5'd12, 5'd11, functAdd);
        jrR31   = rType(regRa, regZero, regZero, functJr);
        swR8    = iType(opSw, 5'd29, 5'd8, 16'd4);
        addUse9 = rType(5'd9, 5'd9, 5'd10, functAdd);

        addRow("afterReset", fillerInstr(), 1'b0, noFwd, noFwd);
        // Load then use on rt, one bubble, then Writeback bypass
        addRow("loadUse.lw", lwR8, 1'b0, noFwd, noFwd);
        addRow("loadUse.stall", addUse, 1'b1, noFwd, noFwd);
        addRow("loadUse.held", addUse, 1'b0, noFwd, noFwd);
        addRow("loadUse.bypassW", beqR8, 1'b0, fwdPair(fwdFromW, fwdNone),
               fwdPair(fwdNone, fwdFromW));
        addRow("loadUse.fill1", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("loadUse.fill2", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("loadUse.fill3", fillerInstr(), 1'b0, noFwd, noFwd);
        // Load two back, branch stalls against Memory on each operand
        addRow("loadM.lwRt", lwR8, 1'b0, noFwd, noFwd);
        addRow("loadM.gapRt", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("loadM.stallRt", iType(opBeq, regZero, 5'd8, 16'd3), 1'b1, noFwd, noFwd);
        addRow("loadM.heldRt", iType(opBeq, regZero, 5'd8, 16'd3), 1'b0,
               fwdPair(fwdNone, fwdFromW), noFwd);
        addRow("loadM.lwRs", lwR8, 1'b0, noFwd, noFwd);
        addRow("loadM.gapRs", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("loadM.stallRs", beqR8, 1'b1, noFwd, noFwd);
        addRow("loadM.heldRs", beqR8, 1'b0, fwdPair(fwdFromW, fwdNone), noFwd);
        addRow("loadM.fill", fillerInstr(), 1'b0, noFwd, noFwd);
        // Branch reads an ALU result in Decode
        addRow("aluBranch.add", addR9, 1'b0, noFwd, noFwd);
        addRow("aluBranch.stall", beqR9, 1'b1, noFwd, noFwd);
        addRow("aluBranch.held", beqR9, 1'b0, fwdPair(fwdFromM, fwdNone), noFwd);
        addRow("aluBranch.fill1", fillerInstr(), 1'b0, noFwd, fwdPair(fwdFromW, fwdNone));
        addRow("aluBranch.fill2", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("aluBranch.fill3", fillerInstr(), 1'b0, noFwd, noFwd);
        // Producers whose result is already there
        addRow("ready.jal", jType(opJal, 26'h40), 1'b0, noFwd, noFwd);
        addRow("ready.jr", jrR31, 1'b0, fwdPair(fwdFromE, fwdNone), noFwd);
        addRow("ready.jrInE", fillerInstr(), 1'b0, noFwd, fwdPair(fwdFromM, fwdNone));
        addRow("ready.fill1", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("ready.add", addR10, 1'b0, noFwd, noFwd);
        addRow("ready.use", addR11, 1'b0, noFwd, noFwd);
        addRow("ready.bypassM", fillerInstr(), 1'b0, noFwd, fwdPair(fwdFromM, fwdNone));
        addRow("ready.fill2", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("ready.fill3", fillerInstr(), 1'b0, noFwd, noFwd);
        // r0, late store data and unknown opcodes
        addRow("zero.write", iType(opAddi, 5'd12, regZero, 16'd1), 1'b0, noFwd, noFwd);
        addRow("zero.read", iType(opBeq, regZero, regZero, 16'd1), 1'b0, noFwd, noFwd);
        addRow("zero.lw", lwR8, 1'b0, noFwd, noFwd);
        addRow("zero.store", swR8, 1'b0, noFwd, noFwd);
        addRow("zero.unknown", iType(6'h3f, 5'd8, 5'd8, 16'd0), 1'b0, noFwd, noFwd);
        addRow("zero.fill1", fillerInstr(), 1'b0, noFwd, noFwd);
        addRow("zero.fill2", fillerInstr(), 1'b0, noFwd, noFwd);
        // Two writers of r9, nearest one wins
        addRow("priority.addi", iType(opAddi, 5'd12, 5'd9, 16'd1), 1'b0, noFwd, noFwd);
        addRow("priority.lui", iType(opLui, regZero, 5'd9, 16'h1234), 1'b0, noFwd, noFwd);
        addRow("priority.use", addUse9, 1'b0, fwdPair(fwdFromE, fwdFromE), noFwd);
        addRow("priority.inE", fillerInstr(), 1'b0, noFwd, fwdPair(fwdFromM, fwdFromM));
        addRow("priority.fill", fillerInstr(), 1'b0, noFwd, noFwd);
    endtask

    task automatic checkOutputs(input string name, input logic expStall, input fwdSel expD,
                                input fwdSel expE);
        checks = checks + 3;
        assert (stall === expStall) else begin
            $display("ERR %s stall expected %0b actual %0b", name, expStall, stall);
            errors = errors + 1;
        end
        assert (fwdD === expD) else begin
            $display("ERR %s fwdD expected rs%0d rt%0d actual rs%0d rt%0d",
                     name, expD.rs, expD.rt, fwdD.rs, fwdD.rt);
            errors = errors + 1;
        end
        assert (fwdE === expE) else begin
            $display("ERR %s fwdE expected rs%0d rt%0d actual rs%0d rt%0d",
                     name, expE.rs, expE.rt, fwdE.rs, fwdE.rt);
            errors = errors + 1;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        seedDummy = $urandom(32'h9dadd5f1);
        buildTable();
        rst   <= 1'b1;
        instr <= fillerInstr();

        // Three reset cycles, checked 1 ns before each next edge
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            if (c == 2) begin
                rst <= 1'b0;
            end
            instr <= fillerInstr();
            #3;
            checkOutputs("reset", 1'b0, noFwd, noFwd);
        end

        for (int i = 0; i < rowInstr.size(); i++) begin
            @(posedge clk);
            instr <= rowInstr[i];
            #3;
            checkOutputs(rowName[i], rowStall[i], rowFwdD[i], rowFwdE[i]);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog, sized from the table length
    initial begin
        int limitNs;
        #1;
        limitNs = (rowInstr.size() + 3 + 20) * 4;
        #(limitNs);
        $display("Timeout: the test sequence did not finish within %0d ns", limitNs);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== hazardUnit.f ====
hw/hazardPkg.sv
hw/atDecoder.sv
hw/atPipeline.sv
hw/stallDetector.sv
hw/forwardSelect.sv
hw/hazardUnit.sv
tests/hazardUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hazardUnitTb
RTL_TOP   ?= hazardUnit
FILELIST  ?= hazardUnit.f
OBJDIR    ?= obj_dir
COMMON    := --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only $(COMMON)
SIMFLAGS  := --binary -j 0 $(COMMON)
PASSMSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)
